// ==== source/kvs_resp_params.svh ====
//------------------------------
// kvs response path constants
// widths, buffer depths, listen
// port range and beat size
//------------------------------
`ifndef KVS_RESP_PARAMS_SVH
`define KVS_RESP_PARAMS_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define KVS_WORD_W          64
`define KVS_SESSION_W       16
`define KVS_LEN_W           16
`define KVS_PORT_W          16

// ------------------------------
// listen ports, 2880 .. 2887
// ------------------------------
`define KVS_FIRST_PORT      2880
`define KVS_PORT_COUNT      8

// every beat counts as a full 64-bit word
`define KVS_BYTES_PER_BEAT  8

// queue depth also bounds the longest frame
`define KVS_QUEUE_DEPTH     16
// keep this at least the queue depth so the meter never stalls
`define KVS_META_DEPTH      16

`endif

// ==== source/kvs_resp_pkg.sv ====
//------------------------------
// kvs response path types
// vector typedefs shared by the
// framer and the joiner FSM state
//------------------------------
`include "kvs_resp_params.svh"

package kvs_resp_pkg;

  // ------------------------------
  // payload and header fields
  // ------------------------------
  // one response beat from the store
  typedef logic [`KVS_WORD_W-1:0]    word_t;
  // session the response belongs to
  typedef logic [`KVS_SESSION_W-1:0] session_t;
  // frame length in bytes
  typedef logic [`KVS_LEN_W-1:0]     frame_len_t;
  // tcp listen port number
  typedef logic [`KVS_PORT_W-1:0]    port_t;

  // ------------------------------
  // joiner FSM
  // ------------------------------
  typedef enum logic [1:0] {
    idle,
    send_meta,
    send_data
  } joiner_state_t;

endpackage

// ==== source/kvs_resp_ifs.sv ====
//------------------------------
// kvs response path interfaces
// beat stream with last flag and
// per-frame tx metadata record
//------------------------------
`timescale 1ns/10ps

// a beat moves when valid and ready are both high
interface resp_stream_if import kvs_resp_pkg::*; ();
  logic  valid;
  logic  ready;
  word_t data;
  logic  last;

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

  // passive observer, sees accepted beats only
  modport monitor (
    input valid,
    input ready,
    input data,
    input last
  );
endinterface

// one record per frame, same handshake rule
interface tx_meta_if import kvs_resp_pkg::*; ();
  logic       valid;
  logic       ready;
  session_t   session;
  frame_len_t len;

  modport source (output valid, output session, output len, input ready);
  modport sink (input valid, input session, input len, output ready);
endinterface

// ==== source/listen_port_opener.sv ====
//------------------------------
// listen port opener
// announces ports 2880 .. 2887
// after reset, one pulse each
//------------------------------
`timescale 1ns/10ps
`include "kvs_resp_params.svh"

module listen_port_opener import kvs_resp_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  listen_port_ready,
  output logic  listen_port_valid,
  output port_t listen_port_data
);

  // one past the last port announced
  localparam port_t END_PORT = port_t'(`KVS_FIRST_PORT + `KVS_PORT_COUNT);

  port_t next_port;
  logic  pulse;

  // pulse is a single cycle strobe, never held while waiting for ready
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pulse     <= 1'b0;
      next_port <= port_t'(`KVS_FIRST_PORT);
    end else begin
      pulse <= 1'b0;
      if (!pulse && listen_port_ready && (next_port < END_PORT)) begin
        pulse     <= 1'b1;
        next_port <= next_port + port_t'(1);
      end
    end
  end

  // port number travels with the pulse
  always_ff @(posedge aclk) begin
    if (!pulse && listen_port_ready && (next_port < END_PORT)) begin
      listen_port_data <= next_port;
    end
  end

  assign listen_port_valid = pulse;

endmodule

// ==== source/resp_word_queue.sv ====
//------------------------------
// response word queue
// circular FIFO holding store
// beats with their last flags
//------------------------------
`timescale 1ns/10ps
`include "kvs_resp_params.svh"

module resp_word_queue import kvs_resp_pkg::*; (
  input  logic          aclk,
  input  logic          aresetn,
  resp_stream_if.sink   in_stream,
  resp_stream_if.source word_stream
);

  localparam int DEPTH = `KVS_QUEUE_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  word_t          data_mem [DEPTH];
  logic           last_mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [CW-1:0]  count;
  logic           push;
  logic           pop;

  assign push = in_stream.valid && in_stream.ready;
  assign pop  = word_stream.valid && word_stream.ready;

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (push) begin
      data_mem[wr_ptr] <= in_stream.data;
      last_mem[wr_ptr] <= in_stream.last;
    end
  end

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      // simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count <= count + CW'(1);
      end else if (pop && !push) begin
        count <= count - CW'(1);
      end
    end
  end

  // accept while there is room, head is read straight from storage
  assign in_stream.ready  = (count != CW'(DEPTH));
  assign word_stream.valid = (count != '0);
  assign word_stream.data  = data_mem[rd_ptr];
  assign word_stream.last  = last_mem[rd_ptr];

endmodule

// ==== source/frame_meter.sv ====
//------------------------------
// frame meter
// measures each frame on the input
// stream and queues its tx record
//------------------------------
`timescale 1ns/10ps
`include "kvs_resp_params.svh"

module frame_meter import kvs_resp_pkg::*; (
  input  logic          aclk,
  input  logic          aresetn,
  input  session_t      resp_session,
  resp_stream_if.monitor in_stream,
  tx_meta_if.source     meta
);

  localparam int DEPTH = `KVS_META_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);
  localparam frame_len_t BEAT_BYTES = frame_len_t'(`KVS_BYTES_PER_BEAT);

  logic          beat;
  logic          first_beat;
  session_t      cur_session;
  frame_len_t    cur_len;
  session_t      frame_session;
  frame_len_t    frame_len;

  session_t      sess_mem [DEPTH];
  frame_len_t    len_mem  [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign beat = in_stream.valid && in_stream.ready;

  // session comes from the first beat only, length grows per beat
  assign frame_session = first_beat ? resp_session : cur_session;
  assign frame_len     = first_beat ? BEAT_BYTES : cur_len + BEAT_BYTES;

  // ------------------------------
  // running frame state
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      first_beat <= 1'b1;
    end else if (beat) begin
      first_beat <= in_stream.last;
    end
  end

  always_ff @(posedge aclk) begin
    if (beat) begin
      cur_session <= frame_session;
      cur_len     <= frame_len;
    end
  end

  // ------------------------------
  // record ring
  // ------------------------------
  assign push = beat && in_stream.last;
  assign pop  = meta.valid && meta.ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      sess_mem[wr_ptr] <= frame_session;
      len_mem[wr_ptr]  <= frame_len;
    end
  end

  // no full check, every pending record has its data still in the word queue
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      if (push && !pop) begin
        count <= count + CW'(1);
      end else if (pop && !push) begin
        count <= count - CW'(1);
      end
    end
  end

  assign meta.valid   = (count != '0);
  assign meta.session = sess_mem[rd_ptr];
  assign meta.len     = len_mem[rd_ptr];

endmodule

// ==== source/tx_frame_joiner.sv ====
//------------------------------
// tx frame joiner
// sends a frame's metadata, then
// releases its data beats
//------------------------------
`timescale 1ns/10ps

module tx_frame_joiner import kvs_resp_pkg::*; (
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        tx_meta_ready,
  input  logic        tx_data_ready,
  tx_meta_if.sink     meta,
  resp_stream_if.sink word_stream,
  output logic        tx_meta_valid,
  output session_t    tx_meta_session,
  output frame_len_t  tx_meta_len,
  output logic        tx_data_valid,
  output word_t       tx_data,
  output logic        tx_data_last
);

  joiner_state_t state;
  logic          meta_take;
  logic          data_take;

  // records are pulled only while idle, one frame in flight
  assign meta.ready = (state == idle);
  assign meta_take  = meta.valid && meta.ready;
  assign data_take  = word_stream.valid && word_stream.ready;

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (meta_take) begin
            state <= send_meta;
          end
        end
        send_meta: begin
          if (tx_meta_ready) begin
            state <= send_data;
          end
        end
        send_data: begin
          // frame ends with the accepted last beat
          if (data_take && word_stream.last) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // record held here until the tx side takes it
  always_ff @(posedge aclk) begin
    if (meta_take) begin
      tx_meta_session <= meta.session;
      tx_meta_len     <= meta.len;
    end
  end

  assign tx_meta_valid = (state == send_meta);

  // data path is open only in send_data, queue head stays put while stalled
  assign tx_data_valid     = (state == send_data) && word_stream.valid;
  assign word_stream.ready = (state == send_data) && tx_data_ready;
  assign tx_data           = word_stream.data;
  assign tx_data_last      = word_stream.last;

endmodule

// ==== source/kvs_resp_top.sv ====
//------------------------------
// kvs response path top level
// listen port opener and the
// response framer toward tx
//------------------------------
`timescale 1ns/10ps

module kvs_resp_top import kvs_resp_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  // listen port announcement
  output logic       listen_port_valid,
  input  logic       listen_port_ready,
  output port_t      listen_port_data,

  // responses from the store
  input  logic       resp_valid,
  output logic       resp_ready,
  input  word_t      resp_data,
  input  session_t   resp_session,
  input  logic       resp_last,

  // tx metadata
  output logic       tx_meta_valid,
  input  logic       tx_meta_ready,
  output session_t   tx_meta_session,
  output frame_len_t tx_meta_len,

  // tx data
  output logic       tx_data_valid,
  input  logic       tx_data_ready,
  output word_t      tx_data,
  output logic       tx_data_last
);

  resp_stream_if in_stream ();
  resp_stream_if word_stream ();
  tx_meta_if     meta ();

  assign in_stream.valid = resp_valid;
  assign in_stream.data  = resp_data;
  assign in_stream.last  = resp_last;
  assign resp_ready      = in_stream.ready;

  listen_port_opener i_listen_port_opener (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .listen_port_ready (listen_port_ready),
    .listen_port_valid (listen_port_valid),
    .listen_port_data  (listen_port_data)
  );

  // queue and meter see the same accepted beats
  resp_word_queue i_resp_word_queue (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .in_stream   (in_stream),
    .word_stream (word_stream)
  );

  frame_meter i_frame_meter (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .resp_session (resp_session),
    .in_stream    (in_stream),
    .meta         (meta)
  );

  tx_frame_joiner i_tx_frame_joiner (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .tx_meta_ready   (tx_meta_ready),
    .tx_data_ready   (tx_data_ready),
    .meta            (meta),
    .word_stream     (word_stream),
    .tx_meta_valid   (tx_meta_valid),
    .tx_meta_session (tx_meta_session),
    .tx_meta_len     (tx_meta_len),
    .tx_data_valid   (tx_data_valid),
    .tx_data         (tx_data),
    .tx_data_last    (tx_data_last)
  );

endmodule

// ==== sim/kvs_resp_checker.sv ====
//------------------------------
// kvs response path checker
// handshake and ordering rules
// on the top level tx ports
//------------------------------
`timescale 1ns/10ps

module kvs_resp_checker import kvs_resp_pkg::*; (
  input logic       aclk,
  input logic       aresetn,
  input logic       listen_port_valid,
  input logic       tx_meta_valid,
  input logic       tx_meta_ready,
  input session_t   tx_meta_session,
  input frame_len_t tx_meta_len,
  input logic       tx_data_valid,
  input logic       tx_data_ready,
  input word_t      tx_data,
  input logic       tx_data_last
);

  int unsigned fail_count = 0;
  logic        meta_done;

  // high from an accepted record until its last data beat
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      meta_done <= 1'b0;
    end else if (tx_meta_valid && tx_meta_ready) begin
      meta_done <= 1'b1;
    end else if (tx_data_valid && tx_data_ready && tx_data_last) begin
      meta_done <= 1'b0;
    end
  end

  a_listen_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    listen_port_valid |=> !listen_port_valid)
    else begin
      fail_count++;
      $error("listen port pulse longer than one cycle");
    end

  a_data_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_data_valid && !tx_data_ready |=>
      tx_data_valid && $stable(tx_data) && $stable(tx_data_last))
    else begin
      fail_count++;
      $error("tx data changed while stalled");
    end

  a_meta_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_meta_valid && !tx_meta_ready |=>
      tx_meta_valid && $stable(tx_meta_session) && $stable(tx_meta_len))
    else begin
      fail_count++;
      $error("tx metadata changed while stalled");
    end

  a_data_after_meta: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_data_valid |-> meta_done)
    else begin
      fail_count++;
      $error("tx data valid before its metadata was accepted");
    end

endmodule

bind kvs_resp_top kvs_resp_checker i_checker (
  .aclk              (aclk),
  .aresetn           (aresetn),
  .listen_port_valid (listen_port_valid),
  .tx_meta_valid     (tx_meta_valid),
  .tx_meta_ready     (tx_meta_ready),
  .tx_meta_session   (tx_meta_session),
  .tx_meta_len       (tx_meta_len),
  .tx_data_valid     (tx_data_valid),
  .tx_data_ready     (tx_data_ready),
  .tx_data           (tx_data),
  .tx_data_last      (tx_data_last)
);

// ==== sim/kvs_resp_tb.sv ====
//------------------------------
// kvs response path testbench
// plays the store and the tx side,
// checks listen ports and frames
//------------------------------
`timescale 1ns/10ps
`include "kvs_resp_params.svh"

module kvs_resp_tb import kvs_resp_pkg::*; ();

  localparam int NUM_FRAMES = 40;
  localparam int MAX_BEATS  = `KVS_QUEUE_DEPTH;

  typedef logic [79:0] val_t;

  logic       aclk = 1'b0;
  logic       aresetn;
  logic       listen_port_valid, listen_port_ready;
  port_t      listen_port_data;
  logic       resp_valid, resp_ready, resp_last;
  word_t      resp_data;
  session_t   resp_session;
  logic       tx_meta_valid;
  logic       tx_meta_ready = 1'b0;
  session_t   tx_meta_session;
  frame_len_t tx_meta_len;
  logic       tx_data_valid, tx_data_last;
  logic       tx_data_ready = 1'b0;
  word_t      tx_data;

  // frame 0 is the single beat frame
  int         frame_beats [NUM_FRAMES + 1];
  word_t      beat_data   [NUM_FRAMES + 1][MAX_BEATS];
  session_t   beat_sess   [NUM_FRAMES + 1][MAX_BEATS];

  // expected tx traffic in arrival order
  logic [31:0] exp_meta [$];
  logic [64:0] exp_data [$];

  logic [31:0] lfsr_state;
  string       test_name;
  int          errors, checks, tests;
  int          cycle_limit;
  int          pulses = 0;
  int          cycles = 0;
  logic        ready_seen = 1'b0;
  logic        meta_open = 1'b0;
  logic        saw_full = 1'b0;
  logic        rand_ready = 1'b0;

  kvs_resp_top i_dut (.*);

  always #50 aclk = ~aclk;

  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected record holds the first beat's session and 8 bytes per beat
  function automatic logic [31:0] frame_meta(input session_t first_sess, input int beats);
    frame_len_t len;
    len = frame_len_t'(beats * `KVS_BYTES_PER_BEAT);
    return {first_sess, len};
  endfunction

  task automatic check_value(input string what, input val_t expected, input val_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    errors++;
    $display("%s: %s", test_name, text);
  endtask

  task automatic send_beat(input word_t d, input session_t s, input logic l);
    resp_valid   = 1'b1;
    resp_data    = d;
    resp_session = s;
    resp_last    = l;
    @(negedge aclk);
    while (!resp_ready) begin
      @(negedge aclk);
    end
    @(posedge aclk);
    #1;
    resp_valid = 1'b0;
  endtask

  task automatic send_frame(input int f);
    exp_meta.push_back(frame_meta(beat_sess[f][0], frame_beats[f]));
    for (int b = 0; b < frame_beats[f]; b++) begin
      exp_data.push_back({(b == frame_beats[f] - 1), beat_data[f][b]});
    end
    for (int b = 0; b < frame_beats[f]; b++) begin
      send_beat(beat_data[f][b], beat_sess[f][b], (b == frame_beats[f] - 1));
    end
  endtask

  task automatic wait_drained();
    while (exp_meta.size() != 0 || exp_data.size() != 0) begin
      @(negedge aclk);
    end
  endtask

  task automatic end_test(input int errors_before);
    tests++;
    $display("test %-14s done, %0d mismatches", test_name, errors - errors_before);
  endtask

  // ------------------------------
  // tx side ready patterns
  // ------------------------------
  always @(posedge aclk) begin
    #1;
    if (rand_ready) begin
      tx_meta_ready = 1'(rand_bits(1));
      tx_data_ready = 1'(rand_bits(1));
    end else begin
      tx_meta_ready = 1'b1;
      tx_data_ready = 1'b1;
    end
  end

  // listen port pulses need ready at the edge before them
  always @(negedge aclk) begin
    if (listen_port_valid) begin
      if (!ready_seen) begin
        report_failure("listen port pulse without a sampled ready");
      end
      check_value("listen_port", val_t'(`KVS_FIRST_PORT + pulses), val_t'(listen_port_data));
      pulses++;
    end
    ready_seen = listen_port_ready;
  end

  // ------------------------------
  // compare tx traffic with the model
  // ------------------------------
  always @(negedge aclk) begin
    if (aresetn && tx_meta_valid && tx_meta_ready) begin
      if (meta_open) begin
        report_failure("metadata arrived before the previous frame ended");
      end
      if (exp_meta.size() == 0) begin
        report_failure("unexpected metadata record");
      end else begin
        check_value("meta", val_t'(exp_meta.pop_front()), val_t'({tx_meta_session, tx_meta_len}));
      end
      meta_open = 1'b1;
    end
    if (aresetn && tx_data_valid && tx_data_ready) begin
      if (!meta_open) begin
        report_failure("data beat before its metadata");
      end
      if (exp_data.size() == 0) begin
        report_failure("unexpected data beat");
      end else begin
        check_value("data", val_t'(exp_data.pop_front()), val_t'({tx_data_last, tx_data}));
      end
      if (tx_data_last) begin
        meta_open = 1'b0;
      end
    end
    if (!resp_ready) begin
      saw_full = 1'b1;
    end
  end

  // run limit from the total number of beats sent
  initial begin
    do begin
      @(posedge aclk);
      cycles++;
    end while (cycles < cycle_limit);
    $display("timeout: traffic did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int total_beats;
    int errors_before;
    lfsr_state        = 32'hb463_c5b6;
    errors            = 0;
    checks            = 0;
    tests             = 0;
    aresetn           = 1'b0;
    listen_port_ready = 1'b0;
    resp_valid        = 1'b0;
    resp_data         = '0;
    resp_session      = '0;
    resp_last         = 1'b0;
    test_name         = "listen_ports";

    // each random frame is sent once freely and once under back-pressure
    total_beats = 1;
    for (int f = 0; f <= NUM_FRAMES; f++) begin
      frame_beats[f] = (f == 0) ? 1 : int'(rand_bits(4)) + 1;
      for (int b = 0; b < frame_beats[f]; b++) begin
        beat_data[f][b] = rand_bits(64);
        beat_sess[f][b] = session_t'(rand_bits(16));
      end
      if (f != 0) begin
        total_beats += 2 * frame_beats[f];
      end
    end
    cycle_limit = 4 * total_beats + 500;

    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // ready drops for a while in the middle of the listen port sequence
    errors_before = errors;
    @(negedge aclk);
    check_value("reset_resp_ready", val_t'(1), val_t'(resp_ready));
    check_value("reset_valids", val_t'(0),
                val_t'({listen_port_valid, tx_meta_valid, tx_data_valid}));
    @(posedge aclk);
    #1;
    listen_port_ready = 1'b1;
    repeat (3) @(posedge aclk);
    #1;
    listen_port_ready = 1'b0;
    repeat (6) @(posedge aclk);
    #1;
    listen_port_ready = 1'b1;
    while (pulses < `KVS_PORT_COUNT) begin
      @(negedge aclk);
    end
    repeat (10) @(negedge aclk);
    check_value("port_count", val_t'(`KVS_PORT_COUNT), val_t'(pulses));
    end_test(errors_before);

    test_name = "single_beat";
    errors_before = errors;
    @(posedge aclk);
    #1;
    send_frame(0);
    wait_drained();
    end_test(errors_before);

    test_name = "random_frames";
    errors_before = errors;
    @(posedge aclk);
    #1;
    for (int f = 1; f <= NUM_FRAMES; f++) begin
      send_frame(f);
    end
    wait_drained();
    end_test(errors_before);

    test_name = "backpressure";
    errors_before = errors;
    @(negedge aclk);
    rand_ready = 1'b1;
    saw_full   = 1'b0;
    @(posedge aclk);
    #1;
    for (int f = 1; f <= NUM_FRAMES; f++) begin
      send_frame(f);
    end
    wait_drained();
    if (!saw_full) begin
      report_failure("resp_ready never fell under back-pressure");
    end
    rand_ready = 1'b0;
    end_test(errors_before);

    test_name = "summary";
    repeat (5) @(negedge aclk);
    check_value("port_count_end", val_t'(`KVS_PORT_COUNT), val_t'(pulses));
    if (i_dut.i_checker.fail_count != 0) begin
      report_failure("checker assertions failed");
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/kvs_resp_pkg.sv
source/kvs_resp_ifs.sv
source/listen_port_opener.sv
source/resp_word_queue.sv
source/frame_meter.sv
source/tx_frame_joiner.sv
source/kvs_resp_top.sv
sim/kvs_resp_checker.sv
sim/kvs_resp_tb.sv

// ==== Makefile ====
# Verilator build and run of the kvs response path testbench

VERILATOR ?= verilator
TOP       ?= kvs_resp_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_EXE) | tee $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
